/* include/memmap_config.svh */
`ifndef MEMMAP_CONFIG_SVH
`define MEMMAP_CONFIG_SVH

// Bus widths.
`define MM_ADDR_W 32
`define MM_DATA_W 32

// UART transmitter window.
`define UART_TX_BASE 32'hF000_0000
`define UART_TX_END  32'hF000_000F

// UART receiver window.
`define UART_RX_BASE 32'hF000_0010
`define UART_RX_END  32'hF000_001F

// Everything outside the UART windows lands in RAM, wrapping at this depth.
`define RAM_WORDS 1024

// Clocks per serial bit.
`define UART_CLKS_PER_BIT 8

// Receive queue entries.
`define RX_QUEUE_DEPTH 4

`endif

/* hw/memmap_pkg.sv */
`include "memmap_config.svh"

package memmap_pkg;

    typedef logic [`MM_ADDR_W-1:0] addr_t;
    typedef logic [`MM_DATA_W-1:0] data_t;
    typedef logic [7:0]            uart_byte_t;

    // Command from the requester, or from the controller to one target.
    typedef struct packed {
        logic  start;
        logic  write;
        addr_t addr;
        data_t wdata;
    } mm_req_t;

    // Response back towards the requester.
    typedef struct packed {
        logic  ready;
        data_t rdata;
        logic  rdata_valid;
    } mm_rsp_t;

    typedef enum logic [1:0] {
        tgt_uart_tx,
        tgt_uart_rx,
        tgt_ram
    } target_e;

    // Frame position, used by both the transmitter and the receiver.
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } uart_state_e;

endpackage

/* hw/ram_port.sv */
`timescale 1ns/100ps
`include "memmap_config.svh"

module ram_port
    import memmap_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  mm_req_t req,
    output mm_rsp_t rsp
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    data_t            mem [`RAM_WORDS];
    logic [IDX_W-1:0] idx;
    data_t            rdata_q;
    logic             rdata_valid_q;

    // Upper address bits fall away so the RAM wraps.
    assign idx = req.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (req.start) begin
            if (req.write) begin
                mem[idx] <= req.wdata;
            end else begin
                rdata_q <= mem[idx];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid_q <= 1'b0;
        end else begin
            rdata_valid_q <= req.start && !req.write;   // One cycle after the read.
        end
    end

    assign rsp = mm_rsp_t'{ready: 1'b1, rdata: rdata_q, rdata_valid: rdata_valid_q};

endmodule

/* hw/uart_tx_port.sv */
`timescale 1ns/100ps
`include "memmap_config.svh"

module uart_tx_port
    import memmap_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  mm_req_t req,
    output mm_rsp_t rsp,
    output logic    uart_tx
);

    localparam int    CNT_W      = $clog2(`UART_CLKS_PER_BIT);
    localparam addr_t DATA_OFS   = addr_t'(0);
    localparam addr_t STATUS_OFS = addr_t'(4);

    uart_state_e      state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    uart_byte_t       shift;
    logic             bit_end;
    logic             busy;
    logic             ready;
    logic             accept;
    logic             load;
    data_t            rdata_q;
    logic             rdata_valid_q;

    assign busy    = (state != st_idle);
    assign bit_end = (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));

    // Writes wait while a frame is on the line; status reads always go through.
    assign ready  = !busy || !req.write;
    assign accept = req.start && ready;
    assign load   = accept && req.write && (req.addr == DATA_OFS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (load) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        state   <= st_data;
                        bit_idx <= '0;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // LSB goes out first.
    always_ff @(posedge clk) begin
        if (load) begin
            shift <= req.wdata[7:0];
        end else if (state == st_data && bit_end) begin
            shift <= shift >> 1;
        end
    end

    always_comb begin
        case (state)
            st_start: uart_tx = 1'b0;
            st_data:  uart_tx = shift[0];
            default:  uart_tx = 1'b1;   // Idle level and stop bit.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid_q <= 1'b0;
        end else begin
            rdata_valid_q <= accept && !req.write;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !req.write) begin
            rdata_q <= (req.addr == STATUS_OFS) ? data_t'(busy) : '0;
        end
    end

    assign rsp = mm_rsp_t'{ready: ready, rdata: rdata_q, rdata_valid: rdata_valid_q};

endmodule

/* hw/uart_rx_port.sv */
`timescale 1ns/100ps
`include "memmap_config.svh"

module uart_rx_port
    import memmap_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  mm_req_t req,
    output mm_rsp_t rsp,
    input  logic    uart_rx
);

    localparam int    CNT_W     = $clog2(`UART_CLKS_PER_BIT);
    localparam int    PTR_W     = $clog2(`RX_QUEUE_DEPTH);
    localparam int    FILL_W    = $clog2(`RX_QUEUE_DEPTH + 1);
    localparam addr_t DATA_OFS  = addr_t'(0);
    localparam addr_t COUNT_OFS = addr_t'(4);

    logic [1:0]        rx_sync;
    logic              rx_line;
    logic              rx_prev;
    uart_state_e       state;
    logic [CNT_W-1:0]  clk_cnt;
    logic [2:0]        bit_idx;
    uart_byte_t        shift;
    logic              bit_end;
    logic              half_bit;
    uart_byte_t        queue [`RX_QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FILL_W-1:0] count;
    logic              push;
    logic              pop;
    logic              rd_en;
    data_t             rdata_q;
    logic              rdata_valid_q;

    assign rx_line  = rx_sync[1];
    assign bit_end  = (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
    assign half_bit = (clk_cnt == CNT_W'(`UART_CLKS_PER_BIT / 2 - 1));

    // A byte with a bad stop bit or no room left is lost.
    assign push  = (state == st_stop) && bit_end && rx_line &&
                   (count != FILL_W'(`RX_QUEUE_DEPTH));
    assign rd_en = req.start && !req.write;
    assign pop   = rd_en && (req.addr == DATA_OFS) && (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            rx_prev <= rx_line;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                st_idle: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_line) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    if (half_bit) begin   // Re-aligns the counter to mid-bit.
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_line ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && bit_end) begin
            shift <= {rx_line, shift[7:1]};
        end
        if (push) begin
            queue[wr_ptr] <= shift;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`RX_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`RX_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid_q <= 1'b0;
        end else begin
            rdata_valid_q <= rd_en;
        end
    end

    // Bit 8 flags a real byte.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (req.addr == DATA_OFS) begin
                rdata_q <= (count != '0) ? data_t'({1'b1, queue[rd_ptr]}) : '0;
            end else if (req.addr == COUNT_OFS) begin
                rdata_q <= data_t'(count);
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign rsp = mm_rsp_t'{ready: 1'b1, rdata: rdata_q, rdata_valid: rdata_valid_q};

endmodule

/* hw/memory_map_controller.sv */
`timescale 1ns/100ps
`include "memmap_config.svh"

module memory_map_controller
    import memmap_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  mm_req_t req,
    output mm_rsp_t rsp,
    input  logic    uart_rx,
    output logic    uart_tx
);

    target_e target;    // Decoded from the address on the bus now.
    target_e owner;     // Target that took the last command.
    mm_req_t tx_req;
    mm_req_t rx_req;
    mm_req_t ram_req;
    mm_rsp_t tx_rsp;
    mm_rsp_t rx_rsp;
    mm_rsp_t ram_rsp;
    logic    accept;

    always_comb begin
        if (req.addr >= addr_t'(`UART_TX_BASE) && req.addr <= addr_t'(`UART_TX_END)) begin
            target = tgt_uart_tx;
        end else if (req.addr >= addr_t'(`UART_RX_BASE) &&
                     req.addr <= addr_t'(`UART_RX_END)) begin
            target = tgt_uart_rx;
        end else begin
            target = tgt_ram;
        end
    end

    // Only the addressed target sees start and write.
    always_comb begin
        tx_req        = req;
        tx_req.start  = req.start && (target == tgt_uart_tx);
        tx_req.write  = req.write && (target == tgt_uart_tx);
        tx_req.addr   = req.addr - addr_t'(`UART_TX_BASE);  // Offset inside the window.

        rx_req        = req;
        rx_req.start  = req.start && (target == tgt_uart_rx);
        rx_req.write  = req.write && (target == tgt_uart_rx);
        rx_req.addr   = req.addr - addr_t'(`UART_RX_BASE);

        ram_req       = req;
        ram_req.start = req.start && (target == tgt_ram);
        ram_req.write = req.write && (target == tgt_ram);
    end

    uart_tx_port uart_tx_port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (tx_req),
        .rsp     (tx_rsp),
        .uart_tx (uart_tx)
    );

    uart_rx_port uart_rx_port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (rx_req),
        .rsp     (rx_rsp),
        .uart_rx (uart_rx)
    );

    ram_port ram_port_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (ram_req),
        .rsp   (ram_rsp)
    );

    // Ready follows the current address, read data follows the owner.
    always_comb begin
        case (owner)
            tgt_uart_tx: rsp = tx_rsp;
            tgt_uart_rx: rsp = rx_rsp;
            default:     rsp = ram_rsp;
        endcase
        case (target)
            tgt_uart_tx: rsp.ready = tx_rsp.ready;
            tgt_uart_rx: rsp.ready = rx_rsp.ready;
            default:     rsp.ready = ram_rsp.ready;
        endcase
    end

    assign accept = req.start && rsp.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= tgt_ram;
        end else if (accept) begin
            owner <= target;
        end
    end

endmodule

/* tb/memmap_checker.sv */
`timescale 1ns/100ps

module memmap_checker
    import memmap_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  mm_req_t          req,
    input  mm_rsp_t          rsp,
    input  data_t            exp_rdata,
    input  logic             poll_mode,    // Mismatches are expected while polling.
    input  logic             ready_check,
    input  logic [1:0]       give_up,      // 1 poll limit hit, 2 ready never came.
    input  logic             test_done,
    input  logic [3:0]       test_id,
    input  logic [8*12-1:0]  test_name,
    output logic             rd_match,
    output int               err_total,
    output int               tests_run,
    output int               tests_failed
);

    logic pending;    // A read was accepted in the previous cycle.
    int   test_errs;

    assign rd_match = (rsp.rdata === exp_rdata);

    always @(posedge clk or negedge rst_n) begin : watch
        int found;
        found = 0;
        if (!rst_n) begin
            pending      <= 1'b0;
            err_total    <= 0;
            tests_run    <= 0;
            tests_failed <= 0;
            test_errs    <= 0;
        end else begin
            pending <= req.start && rsp.ready && !req.write;
            if (rsp.rdata_valid !== pending) begin
                $display("error rdata_valid: exp %h got %h (test %0d)",
                         pending, rsp.rdata_valid, test_id);
                found = found + 1;
            end
            if (rsp.rdata_valid === 1'b1 && !poll_mode && !rd_match) begin
                $display("error rdata: exp %h got %h (test %0d)", exp_rdata, rsp.rdata, test_id);
                found = found + 1;
            end
            if (ready_check && rsp.ready !== 1'b1) begin
                $display("error ready: exp %h got %h (test %0d)", 1'b1, rsp.ready, test_id);
                found = found + 1;
            end
            if (give_up == 2'd1) begin
                $display("test %0d: the polled value did not show up within 200 reads", test_id);
                found = found + 1;
            end else if (give_up == 2'd2) begin
                $display("test %0d: the target never raised ready for a command", test_id);
                found = found + 1;
            end
            err_total <= err_total + found;
            if (test_done) begin
                tests_run <= tests_run + 1;
                test_errs <= 0;
                if (test_errs + found != 0) begin
                    tests_failed <= tests_failed + 1;
                    $display("test %0d %0s: bad, %0d errors", test_id, test_name,
                             test_errs + found);
                end else begin
                    $display("test %0d %0s: ok", test_id, test_name);
                end
            end else begin
                test_errs <= test_errs + found;
            end
        end
    end

endmodule

/* tb/tb_memmap.sv */
`timescale 1ns/100ps
`include "memmap_config.svh"

module tb_memmap
    import memmap_pkg::*;
;

    localparam addr_t TX_DATA   = addr_t'(`UART_TX_BASE);
    localparam addr_t TX_STAT   = addr_t'(`UART_TX_BASE + 4);
    localparam addr_t RX_DATA   = addr_t'(`UART_RX_BASE);
    localparam addr_t RX_COUNT  = addr_t'(`UART_RX_BASE + 4);
    localparam int    NUM_TESTS = 6;

    typedef struct packed {
        logic [3:0] test;
        logic       write;
        addr_t      addr;
        data_t      wdata;
        data_t      exp;
        logic       poll;
    } entry_t;

    logic            clk;
    logic            rst_n;
    mm_req_t         req;
    mm_rsp_t         rsp;
    logic            serial;    // Loopback line from TX to RX.
    data_t           exp_rdata;
    logic            poll_mode;
    logic            ready_check;
    logic [1:0]      give_up;
    logic            test_done;
    logic [3:0]      test_id;
    logic [8*12-1:0] test_name;
    logic [8*12-1:0] names [NUM_TESTS];
    logic            rd_match;
    int              err_total;
    int              tests_run;
    int              tests_failed;
    entry_t          tbl [$];
    int              cycles = 0;
    int              limit = 0;

    memory_map_controller memory_map_controller_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .rsp     (rsp),
        .uart_rx (serial),
        .uart_tx (serial)
    );

    memmap_checker memmap_checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .rsp          (rsp),
        .exp_rdata    (exp_rdata),
        .poll_mode    (poll_mode),
        .ready_check  (ready_check),
        .give_up      (give_up),
        .test_done    (test_done),
        .test_id      (test_id),
        .test_name    (test_name),
        .rd_match     (rd_match),
        .err_total    (err_total),
        .tests_run    (tests_run),
        .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: the run did not end within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic add_entry(input logic [3:0] t, input logic w, input addr_t a,
                             input data_t d, input data_t e, input logic p);
        tbl.push_back(entry_t'{test: t, write: w, addr: a, wdata: d, exp: e, poll: p});
    endtask

    // All tasks below start and end on a falling edge.
    task automatic flag_failure(input logic [1:0] code);
        give_up = code;
        @(negedge clk);
        give_up = 2'd0;
    endtask

    task automatic send(input logic w, input addr_t a, input data_t d);
        int   waits;
        logic taken;
        waits = 0;
        taken = 1'b0;
        req.start = 1'b1;
        req.write = w;
        req.addr  = a;
        req.wdata = d;
        while (!taken && waits < 100) begin    // Start stays up under back-pressure.
            @(posedge clk);
            taken = rsp.ready;
            waits++;
        end
        @(negedge clk);
        req.start = 1'b0;
        req.addr  = (a >= TX_DATA) ? addr_t'(0) : TX_STAT;   // Moves to another target.
        if (!taken) begin
            flag_failure(2'd2);
        end
    endtask

    task automatic read_word(input addr_t a, output logic hit);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        send(1'b0, a, '0);
        while (!seen && n < 4) begin
            @(posedge clk);
            seen = (rsp.rdata_valid === 1'b1);
            n++;
        end
        hit = seen && rd_match;
        @(negedge clk);
    endtask

    task automatic poll_read(input addr_t a);
        int   tries;
        logic hit;
        tries = 0;
        hit   = 1'b0;
        while (!hit && tries < 200) begin
            read_word(a, hit);
            tries++;
        end
        if (!hit) begin
            flag_failure(2'd1);
        end
    endtask

    task automatic check_ready_high();
        req.write   = 1'b1;    // A data write offered without start.
        req.addr    = TX_DATA;
        ready_check = 1'b1;
        @(negedge clk);
        ready_check = 1'b0;
        req.write   = 1'b0;
    endtask

    task automatic finish_test();
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial begin
        int   idx;
        logic hit;
        rst_n       = 1'b0;
        req         = '0;
        exp_rdata   = '0;
        poll_mode   = 1'b0;
        ready_check = 1'b0;
        give_up     = 2'd0;
        test_done   = 1'b0;
        test_id     = '0;
        names[0]    = "ram_rw";
        names[1]    = "ram_alias";
        names[2]    = "tx_status";
        names[3]    = "loopback";
        names[4]    = "rx_order";
        names[5]    = "rd_timing";
        test_name   = names[0];

        add_entry(0, 1, 32'h0000_0000, 32'h1234_5678, '0, 0);
        add_entry(0, 1, 32'h0000_0100, 32'hCAFE_F00D, '0, 0);
        add_entry(0, 1, 32'h0000_0FFC, 32'hA5A5_5A5A, '0, 0);   // Top word.
        add_entry(0, 0, 32'h0000_0000, '0, 32'h1234_5678, 0);
        add_entry(0, 0, 32'h0000_0100, '0, 32'hCAFE_F00D, 0);
        add_entry(0, 0, 32'h0000_0FFC, '0, 32'hA5A5_5A5A, 0);
        add_entry(1, 1, 32'h0000_0010, 32'h1111_1111, '0, 0);
        add_entry(1, 1, 32'h0000_0014, 32'h2222_2222, '0, 0);
        add_entry(1, 0, 32'h0000_0010, '0, 32'h1111_1111, 0);
        add_entry(1, 0, 32'h0000_0014, '0, 32'h2222_2222, 0);
        add_entry(1, 1, 32'h0000_1010, 32'h3333_3333, '0, 0);   // One depth above 0x10.
        add_entry(1, 0, 32'h0000_0010, '0, 32'h3333_3333, 0);
        add_entry(1, 0, 32'h0000_0014, '0, 32'h2222_2222, 0);
        add_entry(2, 1, TX_DATA, 32'h0000_0055, '0, 0);
        add_entry(2, 0, TX_STAT, '0, 32'h0000_0001, 0);
        add_entry(2, 0, TX_STAT, '0, 32'h0000_0000, 1);
        add_entry(2, 0, RX_COUNT, '0, 32'h0000_0001, 1);   // Drain the looped byte.
        add_entry(2, 0, RX_DATA, '0, 32'h0000_0155, 0);
        add_entry(2, 0, RX_COUNT, '0, 32'h0000_0000, 0);
        add_entry(3, 1, TX_DATA, 32'h0000_00A7, '0, 0);
        add_entry(3, 0, RX_COUNT, '0, 32'h0000_0001, 1);
        add_entry(3, 0, RX_DATA, '0, 32'h0000_01A7, 0);
        add_entry(3, 0, RX_COUNT, '0, 32'h0000_0000, 0);
        add_entry(4, 0, RX_DATA, '0, 32'h0000_0000, 0);
        add_entry(4, 1, TX_DATA, 32'h0000_0031, '0, 0);
        add_entry(4, 1, TX_DATA, 32'h0000_0032, '0, 0);
        add_entry(4, 1, TX_DATA, 32'h0000_0033, '0, 0);
        add_entry(4, 0, RX_COUNT, '0, 32'h0000_0003, 1);
        add_entry(4, 0, RX_DATA, '0, 32'h0000_0131, 0);
        add_entry(4, 0, RX_DATA, '0, 32'h0000_0132, 0);
        add_entry(4, 0, RX_DATA, '0, 32'h0000_0133, 0);
        add_entry(4, 0, RX_COUNT, '0, 32'h0000_0000, 0);
        add_entry(4, 0, RX_DATA, '0, 32'h0000_0000, 0);
        add_entry(5, 0, 32'h0000_0000, '0, 32'h1234_5678, 0);
        add_entry(5, 0, TX_STAT, '0, 32'h0000_0000, 0);
        add_entry(5, 0, RX_COUNT, '0, 32'h0000_0000, 0);
        add_entry(5, 0, TX_DATA + 8, '0, 32'h0000_0000, 0);
        add_entry(5, 0, RX_DATA + 8, '0, 32'h0000_0000, 0);
        add_entry(5, 0, 32'h0000_0100, '0, 32'hCAFE_F00D, 0);
        limit = tbl.size() * 200;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (idx = 0; idx < tbl.size(); idx++) begin
            test_id   = tbl[idx].test;
            test_name = names[tbl[idx].test];
            exp_rdata = tbl[idx].exp;
            poll_mode = tbl[idx].poll;
            if (tbl[idx].write) begin
                send(1'b1, tbl[idx].addr, tbl[idx].wdata);
            end else if (tbl[idx].poll) begin
                poll_read(tbl[idx].addr);
            end else begin
                read_word(tbl[idx].addr, hit);
            end
            if (tbl[idx].poll && tbl[idx].addr == TX_STAT) begin
                check_ready_high();   // Frame over, so writes are taken again.
            end
            if (idx == tbl.size() - 1 || tbl[idx + 1].test != tbl[idx].test) begin
                finish_test();
            end
        end

        repeat (2) @(negedge clk);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0 && tests_failed == 0 && tests_run == NUM_TESTS) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/memmap_pkg.sv
hw/ram_port.sv
hw/uart_tx_port.sv
hw/uart_rx_port.sv
hw/memory_map_controller.sv
tb/memmap_checker.sv
tb/tb_memmap.sv
